// ==== rtl/code_pkg.sv ====
// trellis constants, state and decision types, decision packet and branch output function
package code_pkg;

    localparam int CONSTRAINT_LEN = 5;
    localparam int STATE_NUM = 1 << (CONSTRAINT_LEN - 1);   // 16 trellis states

    // tap msb is the oldest bit of the shift register
    localparam logic [CONSTRAINT_LEN-1:0] POLY_G0 = 5'o23;
    localparam logic [CONSTRAINT_LEN-1:0] POLY_G1 = 5'o35;

    // newest input bit at the lsb, next state = {state[2:0], new_bit}
    typedef logic [CONSTRAINT_LEN-2:0] state_t;

    // one bit per state, 1 = survivor came from the predecessor with its oldest bit set
    typedef logic [STATE_NUM-1:0] decision_t;

    typedef struct packed {
        logic      valid;
        logic      last;   // decisions of the final symbol of a frame
        decision_t dec;
    } dec_pkt_t;

    // code bits {g0, g1} for a full register {old_state, new_bit}
    function automatic logic [1:0] branch_bits(input logic [CONSTRAINT_LEN-1:0] shreg);
        logic g0;
        logic g1;
        g0 = ^(shreg & POLY_G0);
        g1 = ^(shreg & POLY_G1);
        return {g0, g1};
    endfunction

endpackage

// ==== rtl/stream_pkg.sv ====
// received symbol struct, tail length and frame position type
package stream_pkg;

    // zero bits that flush the encoder back to state 0, constraint length minus one
    localparam int TAIL_LEN = 4;

    localparam int MAX_FRAME_LEN = 256;   // largest supported frame

    // symbol index inside a frame
    typedef logic [$clog2(MAX_FRAME_LEN)-1:0] frame_pos_t;

    // one hard-decision received symbol
    typedef struct packed {
        logic valid;
        logic last;   // final symbol of the frame
        logic g0;
        logic g1;
    } sym_t;

endpackage

// ==== rtl/acs_array.sv ====
// branch metrics, add-compare-select over all states, start metric reload
`timescale 1ns/1ns

module acs_array #(
    parameter int METRIC_W = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  stream_pkg::sym_t   i_sym,
    output code_pkg::dec_pkt_t o_dec_pkt
);

    localparam int SN = code_pkg::STATE_NUM;

    typedef logic [METRIC_W-1:0] metric_t;

    // half of the modulo compare window, keeps unreachable states behind state 0
    localparam metric_t START_BIAS = metric_t'(1) << (METRIC_W - 2);

    metric_t             path_metric [SN];
    metric_t             metric_next [SN];
    code_pkg::decision_t decision_next;
    logic [1:0]          rx_pair;
    logic                pkt_valid;
    logic                pkt_last;
    code_pkg::decision_t pkt_dec;
    logic                after_last;   // previous valid symbol closed a frame

    assign rx_pair = {i_sym.g0, i_sym.g1};

    // hamming distance between received and expected pair
    function automatic logic [1:0] branch_cost(input logic [1:0] rx, input logic [1:0] exp_bits);
        logic [1:0] diff;
        diff = rx ^ exp_bits;
        return {1'b0, diff[1]} + {1'b0, diff[0]};
    endfunction

    for (genvar n = 0; n < SN; n++)
    begin : g_state
        localparam code_pkg::state_t ST = code_pkg::state_t'(n);
        localparam int P0 = n >> 1;              // predecessor, oldest bit 0
        localparam int P1 = (n >> 1) + SN / 2;   // predecessor, oldest bit 1
        localparam logic [1:0] OUT0 = code_pkg::branch_bits({1'b0, ST});
        localparam logic [1:0] OUT1 = code_pkg::branch_bits({1'b1, ST});

        metric_t sum0;
        metric_t sum1;
        metric_t sum_diff;

        assign sum0 = path_metric[P0] + metric_t'(branch_cost(rx_pair, OUT0));
        assign sum1 = path_metric[P1] + metric_t'(branch_cost(rx_pair, OUT1));

        // wraparound compare, sign of the difference tells which is smaller
        assign sum_diff = sum1 - sum0;
        assign decision_next[n] = sum_diff[METRIC_W-1];   // ties keep predecessor 0
        assign metric_next[n] = decision_next[n] ? sum1 : sum0;
    end

    always_ff @(posedge clk)
    begin
        if (!rst || (i_sym.valid && i_sym.last))
        begin
            // encoder starts every frame in state 0
            for (int s = 0; s < SN; s++)
            begin
                path_metric[s] <= (s == 0) ? metric_t'(0) : START_BIAS;
            end
        end
        else if (i_sym.valid)
        begin
            path_metric <= metric_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            pkt_valid <= 1'b0;
            pkt_last <= 1'b0;
            after_last <= 1'b0;
        end
        else
        begin
            pkt_valid <= i_sym.valid;
            pkt_last <= i_sym.valid && i_sym.last;
            if (i_sym.valid)
                after_last <= i_sym.last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_sym.valid)
            pkt_dec <= decision_next;   // decisions of this trellis step
    end

    assign o_dec_pkt = '{valid: pkt_valid, last: pkt_last, dec: pkt_dec};

    // a frame is never a single symbol long
    a_no_double_last: assert property (@(posedge clk) disable iff (!rst)
        (i_sym.valid && after_last) |-> !i_sym.last)
        else $error("two consecutive frame-end symbols");

endmodule

// ==== rtl/survivor_memory.sv ====
// two-bank survivor store, forward write, reverse read and 2-cycle read pipeline
`timescale 1ns/1ns

module survivor_memory #(
    parameter int FRAME_LEN = 64
) (
    input  logic                clk,
    input  logic                rst,
    input  code_pkg::dec_pkt_t  i_dec_pkt,
    output code_pkg::decision_t o_tb_dec,
    output logic                o_tb_valid,
    output logic                o_tb_last
);

    localparam int ADDR_W = $clog2(FRAME_LEN);
    localparam stream_pkg::frame_pos_t LAST_POS = stream_pkg::frame_pos_t'(FRAME_LEN - 1);

    code_pkg::decision_t    bank_mem [2][FRAME_LEN];
    stream_pkg::frame_pos_t wr_addr;
    logic                   wr_bank;     // bank being filled
    stream_pkg::frame_pos_t rd_addr;
    logic                   rd_bank;     // bank being traced back
    logic                   rd_active;
    logic                   rd_start;
    code_pkg::decision_t    rd_word;     // ram output register
    code_pkg::decision_t    rd_word_q;   // pipeline register
    logic [1:0]             rd_valid_pipe;
    logic [1:0]             rd_last_pipe;

    assign rd_start = i_dec_pkt.valid && i_dec_pkt.last;

    always_ff @(posedge clk)
    begin
        if (i_dec_pkt.valid)
            bank_mem[wr_bank][wr_addr[ADDR_W-1:0]] <= i_dec_pkt.dec;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_addr <= '0;
            wr_bank <= 1'b0;
        end
        else if (i_dec_pkt.valid)
        begin
            if (i_dec_pkt.last)
            begin
                wr_addr <= '0;
                wr_bank <= ~wr_bank;   // next frame goes to the other bank
            end
            else
            begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // reverse read of the bank that was just closed
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            rd_active <= 1'b0;
            rd_addr <= '0;
            rd_bank <= 1'b0;
        end
        else if (rd_start)
        begin
            rd_active <= 1'b1;
            rd_addr <= LAST_POS;
            rd_bank <= wr_bank;
        end
        else if (rd_active)
        begin
            if (rd_addr == '0)
                rd_active <= 1'b0;
            else
                rd_addr <= rd_addr - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        rd_word <= bank_mem[rd_bank][rd_addr[ADDR_W-1:0]];
        rd_word_q <= rd_word;
    end

    // flags follow the data through both registers
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            rd_valid_pipe <= '0;
            rd_last_pipe <= '0;
        end
        else
        begin
            rd_valid_pipe <= {rd_valid_pipe[0], rd_active};
            rd_last_pipe <= {rd_last_pipe[0], rd_active && (rd_addr == '0)};
        end
    end

    assign o_tb_dec = rd_word_q;
    assign o_tb_valid = rd_valid_pipe[1];
    assign o_tb_last = rd_last_pipe[1];

    // the symbol stream and the frame length must agree
    a_last_at_end: assert property (@(posedge clk) disable iff (!rst)
        rd_start |-> (wr_addr == LAST_POS))
        else $error("frame end packet at write address %0d", wr_addr);

    // only the final read step may overlap the next start
    a_no_read_overlap: assert property (@(posedge clk) disable iff (!rst)
        rd_start |-> (!rd_active || rd_addr == '0))
        else $error("traceback read restarted while running");

endmodule

// ==== rtl/traceback_unit.sv ====
// trellis traceback from state 0 and decoded frame assembly
`timescale 1ns/1ns

module traceback_unit #(
    parameter int FRAME_LEN = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  code_pkg::decision_t  i_tb_dec,
    input  logic                 i_tb_valid,
    input  logic                 i_tb_last,
    output logic [FRAME_LEN-1:0] o_frame_bits,
    output logic                 o_frame_valid
);

    localparam int SW = code_pkg::CONSTRAINT_LEN - 1;
    localparam int STEP_W = $clog2(FRAME_LEN);
    localparam logic [STEP_W-1:0] TOP_STEP = STEP_W'(FRAME_LEN - 1);

    // any state is flushed to zero by the tail bits
    localparam code_pkg::state_t ANY_ST = '1;
    localparam code_pkg::state_t START_ST = ANY_ST << stream_pkg::TAIL_LEN;

    code_pkg::state_t     tb_state;     // state after the current step
    code_pkg::state_t     pred_state;
    logic [STEP_W-1:0]    step;         // symbol index of the current word
    logic [FRAME_LEN-1:1] frame_acc;    // bit 0 is taken straight from the last word

    // shift right, oldest bit comes from the stored decision
    assign pred_state = {i_tb_dec[tb_state], tb_state[SW-1:1]};

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            tb_state <= START_ST;
            step <= TOP_STEP;
        end
        else if (i_tb_valid)
        begin
            if (i_tb_last)
            begin
                tb_state <= START_ST;   // ready for the next frame
                step <= TOP_STEP;
            end
            else
            begin
                tb_state <= pred_state;
                step <= step - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_tb_valid && !i_tb_last)
            frame_acc[step] <= tb_state[0];   // newest bit of the state is the data bit
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            o_frame_valid <= 1'b0;
        else
            o_frame_valid <= i_tb_valid && i_tb_last;
    end

    always_ff @(posedge clk)
    begin
        if (i_tb_valid && i_tb_last)
            o_frame_bits <= {frame_acc, tb_state[0]};
    end

endmodule

// ==== rtl/viterbi_decoder.sv ====
// viterbi decoder top level, ACS array, survivor memory and traceback
`timescale 1ns/1ns

module viterbi_decoder #(
    parameter int FRAME_LEN = 64,
    parameter int METRIC_W = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  stream_pkg::sym_t     i_sym,
    output logic [FRAME_LEN-1:0] o_frame_bits,
    output logic                 o_frame_valid
);

    code_pkg::dec_pkt_t  dec_pkt;
    code_pkg::decision_t tb_dec;
    logic                tb_valid;
    logic                tb_last;

    acs_array #(
        .METRIC_W (METRIC_W)
    ) u_acs (
        .clk       (clk),
        .rst       (rst),
        .i_sym     (i_sym),
        .o_dec_pkt (dec_pkt)
    );

    survivor_memory #(
        .FRAME_LEN (FRAME_LEN)
    ) u_surv (
        .clk        (clk),
        .rst        (rst),
        .i_dec_pkt  (dec_pkt),
        .o_tb_dec   (tb_dec),
        .o_tb_valid (tb_valid),
        .o_tb_last  (tb_last)
    );

    traceback_unit #(
        .FRAME_LEN (FRAME_LEN)
    ) u_tb (
        .clk           (clk),
        .rst           (rst),
        .i_tb_dec      (tb_dec),
        .i_tb_valid    (tb_valid),
        .i_tb_last     (tb_last),
        .o_frame_bits  (o_frame_bits),
        .o_frame_valid (o_frame_valid)
    );

endmodule

// ==== testbench/conv_model.svh ====
// reference convolutional encoder, channel error injector and expected frame queue
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// decoded frames still owed by the DUT, with the cycle each one is due
logic [FRAME_LEN-1:0] exp_frames[$];
int unsigned          exp_due[$];

// pair {g0, g1} of symbol t lands at bits [2t+1:2t]
function automatic logic [2*FRAME_LEN-1:0] encode_frame(input logic [FRAME_LEN-1:0] data);
    logic [2*FRAME_LEN-1:0] code;
    logic [CL-1:0]          shreg;       // oldest bit at the msb
    logic [CL-2:0]          enc_state;   // newest bit at the lsb
    enc_state = '0;                      // encoder starts every frame in state 0
    code = '0;
    for (int t = 0; t < FRAME_LEN; t++)
    begin
        shreg = {enc_state, data[t]};
        code[2*t+1] = ^(shreg & code_pkg::POLY_G0);
        code[2*t] = ^(shreg & code_pkg::POLY_G1);
        enc_state = shreg[CL-2:0];
    end
    return code;
endfunction

// flips land on one random slot of every 16-symbol block, so flips are 16 apart
function automatic logic [2*FRAME_LEN-1:0] add_channel_errors(
    input logic [2*FRAME_LEN-1:0] code
);
    logic [2*FRAME_LEN-1:0] noisy;
    int                     offset;
    int                     bit_idx;
    noisy = code;
    offset = int'($urandom_range(ERR_SPACING - 1, 0));
    for (int t = offset; t < FRAME_LEN; t += ERR_SPACING)
    begin
        if ($urandom_range(3, 0) != 0)   // some blocks stay clean
        begin
            bit_idx = 2 * t + int'($urandom_range(1, 0));
            noisy[bit_idx] = ~noisy[bit_idx];
            flip_cnt++;
        end
    end
    return noisy;
endfunction

task automatic push_expected(input logic [FRAME_LEN-1:0] bits, input int unsigned due);
    exp_frames.push_back(bits);
    exp_due.push_back(due);
endtask

task automatic take_expected(output logic [FRAME_LEN-1:0] bits, output int unsigned due);
    bits = exp_frames.pop_front();
    due = exp_due.pop_front();
endtask

`endif

// ==== testbench/tb_viterbi.sv ====
// testbench for the viterbi decoder, random frames, channel errors, gaps and reset
`timescale 1ns/1ns

module tb_viterbi;

    localparam int FRAME_LEN = 64;
    localparam int METRIC_W = 8;
    localparam int CL = code_pkg::CONSTRAINT_LEN;
    localparam int DATA_LEN = FRAME_LEN - stream_pkg::TAIL_LEN;
    localparam int LATENCY = FRAME_LEN + 4;   // last symbol driven to pulse seen
    localparam int ERR_SPACING = 16;
    localparam int DRAIN_LIMIT = 4 * FRAME_LEN;
    localparam int unsigned SEED = 32'h62a5;

    logic                 clk;
    logic                 rst;
    stream_pkg::sym_t     sym;
    logic [FRAME_LEN-1:0] frame_bits;
    logic                 frame_valid;

    int unsigned          cycle_cnt = 0;
    int unsigned          err_cnt = 0;
    int unsigned          frame_cnt = 0;
    int unsigned          flip_cnt = 0;
    bit                   timed_out = 1'b0;
    logic [FRAME_LEN-1:0] mon_bits;
    int unsigned          mon_due;

    `include "conv_model.svh"

    viterbi_decoder #(
        .FRAME_LEN (FRAME_LEN),
        .METRIC_W  (METRIC_W)
    ) u_dut (
        .clk           (clk),
        .rst           (rst),
        .i_sym         (sym),
        .o_frame_bits  (frame_bits),
        .o_frame_valid (frame_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    task automatic check_equal(input logic [FRAME_LEN-1:0] got,
                               input logic [FRAME_LEN-1:0] expected, input string what);
        if (got !== expected)
        begin
            err_cnt++;
            $display("[FAIL] time %0t: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    // output monitor sampled mid-cycle
    always @(negedge clk)
    begin
        if (frame_valid === 1'b1)
        begin
            if (exp_frames.size() == 0)
            begin
                err_cnt++;
                $display("a frame came out at time %0t although none was expected", $time);
            end
            else
            begin
                take_expected(mon_bits, mon_due);
                check_equal(cycle_cnt, mon_due, "frame output cycle");
                check_equal(frame_bits, mon_bits, "decoded frame");
                check_equal(frame_bits[FRAME_LEN-1 -: stream_pkg::TAIL_LEN], '0, "tail bits");
                frame_cnt++;
            end
        end
        else if (exp_due.size() != 0 && cycle_cnt > exp_due[0])
        begin
            err_cnt++;
            $display("no frame arrived by cycle %0d, the frame due then is lost", exp_due[0]);
            take_expected(mon_bits, mon_due);
        end
    end

    function automatic logic [FRAME_LEN-1:0] random_data();
        logic [FRAME_LEN-1:0] data;
        data = '0;                       // tail bits stay zero
        for (int t = 0; t < DATA_LEN; t++)
            data[t] = 1'($urandom_range(1, 0));
        return data;
    endfunction

    task automatic send_symbols(input logic [2*FRAME_LEN-1:0] code, input int count,
                                input int max_gap, output int unsigned last_cycle);
        int gap;
        last_cycle = 0;
        for (int t = 0; t < count; t++)
        begin
            gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            repeat (gap)
            begin
                @(negedge clk);
                sym = 4'($urandom_range(7, 0));   // junk with valid low
            end
            @(negedge clk);
            sym.valid = 1'b1;
            sym.last = (t == FRAME_LEN - 1);
            sym.g0 = code[2*t+1];
            sym.g1 = code[2*t];
            last_cycle = cycle_cnt;
        end
    endtask

    task automatic send_frame(input bit with_errors, input int max_gap);
        logic [FRAME_LEN-1:0]   data;
        logic [2*FRAME_LEN-1:0] code;
        int unsigned            last_cycle;
        data = random_data();
        code = encode_frame(data);
        if (with_errors)
            code = add_channel_errors(code);
        send_symbols(code, FRAME_LEN, max_gap, last_cycle);
        push_expected(data, last_cycle + LATENCY);
    endtask

    // idle the input and wait until every expected frame is out
    task automatic drain();
        int waited;
        @(negedge clk);
        sym = '0;
        waited = 0;
        while (exp_frames.size() != 0 && waited < DRAIN_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_frames.size() != 0)
        begin
            err_cnt++;
            timed_out = 1'b1;
            $display("timeout: no frame arrived within %0d cycles, %0d frames missing",
                     DRAIN_LIMIT, exp_frames.size());
        end
    endtask

    task automatic reset_mid_frame();
        logic [2*FRAME_LEN-1:0] code;
        int unsigned            last_cycle;
        code = encode_frame(random_data());
        send_symbols(code, FRAME_LEN, 0, last_cycle);   // its traceback still runs at reset
        code = encode_frame(random_data());
        send_symbols(code, FRAME_LEN / 2, 0, last_cycle);
        @(negedge clk);
        sym = '0;
        rst = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b1;
        repeat (2 * LATENCY) @(negedge clk);   // any pulse here is caught by the monitor
        send_frame(1'b0, 0);
        drain();
    endtask

    task automatic run_tests();
        for (int f = 0; f < 6; f++)
        begin
            send_frame(1'b0, 0);   // clean channel
            drain();
        end
        for (int f = 0; f < 12; f++)
        begin
            send_frame(1'b1, 0);   // sparse bit flips
            drain();
        end
        if (timed_out)
            return;
        for (int f = 0; f < 24; f++)
            send_frame(1'b0, 0);   // back to back so both banks take turns
        drain();
        for (int f = 0; f < 8; f++)
        begin
            send_frame(1'b1, 3);   // idle cycles between symbols
            drain();
        end
        if (timed_out)
            return;
        reset_mid_frame();
    endtask

    task automatic finish_run();
        $display("errors: %0d, frames checked: %0d, channel bit flips: %0d",
                 err_cnt, frame_cnt, flip_cnt);
        if (err_cnt == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    endtask

    initial
    begin
        void'($urandom(SEED));
        rst = 1'b0;
        sym = '0;
        repeat (4) @(negedge clk);
        rst = 1'b1;
        run_tests();
        finish_run();
    end

endmodule

// ==== all.f ====
+incdir+testbench
rtl/code_pkg.sv
rtl/stream_pkg.sv
rtl/acs_array.sv
rtl/survivor_memory.sv
rtl/traceback_unit.sv
rtl/viterbi_decoder.sv
testbench/tb_viterbi.sv

// ==== Makefile ====
TOP := tb_viterbi

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f $(wildcard rtl/*.sv) $(wildcard testbench/*.sv testbench/*.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir
